// ==== rtl/filter_pkg.sv ====
package filter_pkg;

    // ------------------------------------------------------------------
    // Packet geometry and pipeline depth
    // ------------------------------------------------------------------
    localparam int num_fields    = 4;
    localparam int field_width   = 32;
    localparam int pipe_latency  = 4;

    // Wishbone register port
    localparam int wb_data_width = 32;
    localparam int wb_adr_width  = 2;

    localparam logic [wb_adr_width-1:0] reg_ctrl       = 2'd0;
    localparam logic [wb_adr_width-1:0] reg_const      = 2'd1;
    localparam logic [wb_adr_width-1:0] reg_pass_count = 2'd2;
    localparam logic [wb_adr_width-1:0] reg_drop_count = 2'd3;

    // One packet, field 0 in the low word
    typedef logic [num_fields-1:0][field_width-1:0] engine_fields_t;

    // Codes 5 to 15 are undefined and keep the packet as is
    typedef enum logic [3:0] {
        filter_nop    = 4'd0,
        filter_gt     = 4'd1,
        filter_lt     = 4'd2,
        filter_eq     = 4'd3,
        filter_not_eq = 4'd4
    } filter_op_t;

    // Ctrl register layout, operation in bits 3:0
    // ops_mask[i] is row i, bits 4i+3 down to 4i of the row block
    typedef struct packed {
        logic [3:0]                            reserved;
        logic [num_fields-1:0][num_fields-1:0] ops_mask;
        logic [num_fields-1:0]                 const_mask;
        logic [num_fields-1:0]                 filter_mask;
        filter_op_t                            operation;
    } cfg_ctrl_t;

    // Same Wishbone word seen as ctrl fields or as a plain value
    typedef union packed {
        cfg_ctrl_t                ctrl;
        logic [wb_data_width-1:0] raw;
    } cfg_word_u;

endpackage

// ==== rtl/filter_cfg_if.sv ====
interface filter_cfg_if;

    filter_pkg::filter_op_t                                      operation;
    logic [filter_pkg::num_fields-1:0]                           filter_mask;
    logic [filter_pkg::num_fields-1:0]                           const_mask;
    // Row i picks the source field of operand i
    logic [filter_pkg::num_fields-1:0][filter_pkg::num_fields-1:0] ops_mask;
    logic [filter_pkg::field_width-1:0]                          const_value;

    modport decode (
        output operation,
        output filter_mask,
        output const_mask,
        output ops_mask,
        output const_value
    );

    modport execute (
        input  operation,
        input  filter_mask,
        input  const_mask,
        input  ops_mask,
        input  const_value
    );

endinterface

// ==== rtl/filter_cfg_decode.sv ====
module filter_cfg_decode (
    input  logic                                 ap_clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [filter_pkg::wb_adr_width-1:0]  wb_adr,
    input  logic [filter_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [filter_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                 wb_ack,
    input  logic [filter_pkg::wb_data_width-1:0] pass_count,
    input  logic [filter_pkg::wb_data_width-1:0] drop_count,
    filter_cfg_if.decode                         cfg
);

    filter_pkg::cfg_word_u               ctrl_reg;
    filter_pkg::cfg_word_u               rd_word;
    logic [filter_pkg::field_width-1:0]  const_reg;
    logic                                wb_start;

    // ------------------------------------------------------------------
    // Wishbone classic handshake
    // ------------------------------------------------------------------

    // New request only while ack is low, so each access is answered once
    assign wb_start = wb_cyc && wb_stb && !wb_ack;

    // Read data select
    always_comb begin
        case (wb_adr)
            filter_pkg::reg_ctrl: begin
                rd_word = ctrl_reg;
            end
            filter_pkg::reg_const: begin
                rd_word.raw = const_reg;
            end
            filter_pkg::reg_pass_count: begin
                rd_word.raw = pass_count;
            end
            filter_pkg::reg_drop_count: begin
                rd_word.raw = drop_count;
            end
            default: begin
                rd_word.raw = '0;
            end
        endcase
    end

    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack       <= 1'b0;
            wb_dat_r     <= '0;
            ctrl_reg.raw <= '0;
            const_reg    <= '0;
        end else begin
            wb_ack <= wb_start;
            if (wb_start) begin
                if (wb_we) begin
                    // Counter addresses are read only
                    case (wb_adr)
                        filter_pkg::reg_ctrl: begin
                            ctrl_reg.raw <= wb_dat_w;
                        end
                        filter_pkg::reg_const: begin
                            const_reg <= wb_dat_w;
                        end
                        default: begin
                        end
                    endcase
                end else begin
                    wb_dat_r <= rd_word.raw;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Configuration out to the kernel
    // ------------------------------------------------------------------
    assign cfg.operation   = ctrl_reg.ctrl.operation;
    assign cfg.filter_mask = ctrl_reg.ctrl.filter_mask;
    assign cfg.const_mask  = ctrl_reg.ctrl.const_mask;
    assign cfg.ops_mask    = ctrl_reg.ctrl.ops_mask;
    assign cfg.const_value = const_reg;

endmodule

// ==== rtl/filter_cond_kernel.sv ====
module filter_cond_kernel (
    input  logic                       ap_clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  filter_pkg::engine_fields_t in_fields,
    filter_cfg_if.execute              cfg,
    output logic                       k_valid,
    output filter_pkg::engine_fields_t k_fields,
    output logic                       k_keep
);

    filter_pkg::engine_fields_t               ops_d;
    filter_pkg::engine_fields_t               org_d;
    filter_pkg::engine_fields_t               ops_q;
    filter_pkg::engine_fields_t               org_q;
    filter_pkg::engine_fields_t               res_q;
    logic [filter_pkg::num_fields-1:0]        cmp_pass;
    logic [filter_pkg::num_fields-1:0]        pass_q;
    logic [filter_pkg::pipe_latency-2:0]      valid_sr;

    // Field at the lowest set bit of the row, own field if the row is empty
    function automatic logic [filter_pkg::field_width-1:0] pick_field(
        input filter_pkg::engine_fields_t        fields,
        input logic [filter_pkg::num_fields-1:0] row,
        input int                                self_idx
    );
        logic [filter_pkg::field_width-1:0] val;
        val = fields[self_idx];
        // Scan high to low so the lowest hit wins
        for (int j = filter_pkg::num_fields - 1; j >= 0; j--) begin
            if (row[j]) begin
                val = fields[j];
            end
        end
        return val;
    endfunction

    // ------------------------------------------------------------------
    // Stage 1: operand and original value select
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < filter_pkg::num_fields; i++) begin
            org_d[i] = pick_field(in_fields, cfg.ops_mask[i], i);
            ops_d[i] = cfg.const_mask[i] ? cfg.const_value : org_d[i];
        end
    end

    always_ff @(posedge ap_clk) begin
        ops_q <= ops_d;
        org_q <= org_d;
    end

    // ------------------------------------------------------------------
    // Stage 2: neighbour compare, last field wraps to field 0
    // ------------------------------------------------------------------
    always_comb begin
        logic hit;
        int   nxt;
        for (int i = 0; i < filter_pkg::num_fields; i++) begin
            nxt = (i + 1) % filter_pkg::num_fields;
            case (cfg.operation)
                filter_pkg::filter_gt:     hit = ops_q[i] >  ops_q[nxt];
                filter_pkg::filter_lt:     hit = ops_q[i] <  ops_q[nxt];
                filter_pkg::filter_eq:     hit = ops_q[i] == ops_q[nxt];
                filter_pkg::filter_not_eq: hit = ops_q[i] != ops_q[nxt];
                // NOP and undefined codes always keep
                default:                   hit = 1'b1;
            endcase
            // Unmasked fields never veto
            cmp_pass[i] = hit || !cfg.filter_mask[i];
        end
    end

    always_ff @(posedge ap_clk) begin
        pass_q <= cmp_pass;
        // NOP forwards operands, everything else the original values
        if (cfg.operation == filter_pkg::filter_nop) begin
            res_q <= ops_q;
        end else begin
            res_q <= org_q;
        end
    end

    // ------------------------------------------------------------------
    // Stage 3: verdict reduce
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        k_fields <= res_q;
        k_keep   <= &pass_q;
    end

    // One valid tag per stage
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[filter_pkg::pipe_latency-3:0], in_valid};
        end
    end

    assign k_valid = valid_sr[filter_pkg::pipe_latency-2];

endmodule

// ==== rtl/filter_result_gate.sv ====
module filter_result_gate (
    input  logic                                 ap_clk,
    input  logic                                 rst_n,
    input  logic                                 k_valid,
    input  logic                                 k_keep,
    input  filter_pkg::engine_fields_t           k_fields,
    output logic                                 out_valid,
    output filter_pkg::engine_fields_t           out_fields,
    output logic [filter_pkg::wb_data_width-1:0] pass_count,
    output logic [filter_pkg::wb_data_width-1:0] drop_count
);

    logic keep_pkt;
    logic drop_pkt;

    assign keep_pkt = k_valid && k_keep;
    assign drop_pkt = k_valid && !k_keep;

    // Output register, dropped packets leave no trace on the bus
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_fields <= '0;
        end else begin
            out_valid <= keep_pkt;
            if (keep_pkt) begin
                out_fields <= k_fields;
            end
        end
    end

    // Statistics, wrap on overflow
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_count <= '0;
            drop_count <= '0;
        end else begin
            if (keep_pkt) begin
                pass_count <= pass_count + 1'b1;
            end
            if (drop_pkt) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/graph_filter_engine.sv ====
module graph_filter_engine (
    input  logic                                 ap_clk,
    input  logic                                 rst_n,
    // Wishbone classic slave
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [filter_pkg::wb_adr_width-1:0]  wb_adr,
    input  logic [filter_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [filter_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                 wb_ack,
    // Packet stream
    input  logic                                 in_valid,
    input  filter_pkg::engine_fields_t           in_fields,
    output logic                                 out_valid,
    output filter_pkg::engine_fields_t           out_fields
);

    logic                                 k_valid;
    logic                                 k_keep;
    filter_pkg::engine_fields_t           k_fields;
    logic [filter_pkg::wb_data_width-1:0] pass_count;
    logic [filter_pkg::wb_data_width-1:0] drop_count;

    filter_cfg_if u_cfg_if ();

    filter_cfg_decode u_cfg_decode (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .pass_count (pass_count),
        .drop_count (drop_count),
        .cfg        (u_cfg_if.decode)
    );

    filter_cond_kernel u_cond_kernel (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_fields (in_fields),
        .cfg       (u_cfg_if.execute),
        .k_valid   (k_valid),
        .k_fields  (k_fields),
        .k_keep    (k_keep)
    );

    filter_result_gate u_result_gate (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .k_valid    (k_valid),
        .k_keep     (k_keep),
        .k_fields   (k_fields),
        .out_valid  (out_valid),
        .out_fields (out_fields),
        .pass_count (pass_count),
        .drop_count (drop_count)
    );

endmodule

// ==== sim/filter_engine_asserts.sv ====
module filter_engine_asserts (
    input logic                       ap_clk,
    input logic                       rst_n,
    input logic                       wb_cyc,
    input logic                       wb_stb,
    input logic                       wb_ack,
    input logic [31:0]                wb_dat_r,
    input logic                       in_valid,
    input logic                       out_valid,
    input filter_pkg::engine_fields_t out_fields
);

    // Ack is a one-cycle pulse answering a live request
    ack_pulse: assert property (@(posedge ap_clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for more than one cycle");

    ack_request: assert property (@(posedge ap_clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    // Fixed pipeline latency
    out_latency: assert property (@(posedge ap_clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, filter_pkg::pipe_latency))
        else $error("out_valid without an input packet pipe_latency cycles earlier");

    outputs_known: assert property (@(posedge ap_clk) disable iff (!rst_n)
        !$isunknown({out_valid, out_fields, wb_ack, wb_dat_r}))
        else $error("unknown value on a DUT output");

endmodule

bind graph_filter_engine filter_engine_asserts u_engine_asserts (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_fields (out_fields)
);

// ==== sim/tb_graph_filter_engine.sv ====
module tb_graph_filter_engine;

    localparam int num_rows     = 13;
    localparam int reset_cycles = 8;
    localparam int wb_cycles    = 3;

    // Table row of config, constant, packet count and counter readback flag
    typedef struct packed {
        logic [31:0] ctrl;
        logic [31:0] cval;
        logic [15:0] npkt;
        logic        check_counts;
    } row_t;

    typedef struct packed {
        filter_pkg::engine_fields_t fields;
        logic [31:0]                cycle;
    } expect_t;

    logic                       ap_clk = 1'b0;
    logic                       rst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [1:0]                 wb_adr;
    logic [31:0]                wb_dat_w;
    logic [31:0]                wb_dat_r;
    logic                       wb_ack;
    logic                       in_valid;
    filter_pkg::engine_fields_t in_fields;
    logic                       out_valid;
    filter_pkg::engine_fields_t out_fields;

    row_t        rows [num_rows];
    expect_t     exp_q [$];
    logic [31:0] lcg_state   = 32'd31109;
    int          cyc_count   = 0;
    int          cycle_limit = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          pass_total  = 0;
    int          drop_total  = 0;

    graph_filter_engine u_graph_filter_engine (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .in_valid   (in_valid),
        .in_fields  (in_fields),
        .out_valid  (out_valid),
        .out_fields (out_fields)
    );

    always #5 ap_clk = ~ap_clk;

    // Cycle count and watchdog
    always @(posedge ap_clk) begin
        cyc_count++;
        if (cycle_limit > 0 && cyc_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] make_ctrl(input logic [3:0] op, input logic [3:0] fmask,
                                              input logic [3:0] cmask, input logic [15:0] ops);
        return {4'h0, ops, cmask, fmask, op};
    endfunction

    task automatic set_row(input int idx, input logic [3:0] op, input logic [3:0] fmask,
                           input logic [3:0] cmask, input logic [15:0] ops,
                           input logic [31:0] cval, input int npkt, input bit check);
        rows[idx] = '{ctrl: make_ctrl(op, fmask, cmask, ops), cval: cval,
                      npkt: npkt[15:0], check_counts: check};
    endtask

    // op, filter mask, const mask, ops rows, constant, packets, counter check
    task automatic load_table();
        set_row(0,  4'd0, 4'b0000, 4'b0000, 16'h0000, 32'h0000_0000, 6,  1'b1);
        set_row(1,  4'd1, 4'b0001, 4'b0000, 16'h0000, 32'h0000_0000, 10, 1'b1);
        set_row(2,  4'd1, 4'b1111, 4'b0000, 16'h0000, 32'h0000_0000, 10, 1'b1);
        set_row(3,  4'd2, 4'b0011, 4'b0000, 16'h0000, 32'h0000_0000, 10, 1'b1);
        set_row(4,  4'd3, 4'b0001, 4'b0000, 16'h0000, 32'h0000_0000, 12, 1'b1);
        set_row(5,  4'd3, 4'b1111, 4'b0000, 16'h0000, 32'h0000_0000, 12, 1'b0);
        set_row(6,  4'd4, 4'b0101, 4'b0000, 16'h0000, 32'h0000_0000, 10, 1'b1);
        set_row(7,  4'd3, 4'b0001, 4'b0001, 16'h0000, 32'h1234_5678, 12, 1'b1);
        set_row(8,  4'd1, 4'b0011, 4'b0000, 16'h0004, 32'h0000_0000, 10, 1'b1);
        set_row(9,  4'd0, 4'b0000, 4'b1001, 16'h0200, 32'hcafe_0001, 8,  1'b1);
        set_row(10, 4'd2, 4'b0110, 4'b0000, 16'h6000, 32'h0000_0000, 10, 1'b1);
        set_row(11, 4'd9, 4'b1111, 4'b0011, 16'h1000, 32'h0f0f_0f0f, 8,  1'b0);
        set_row(12, 4'd4, 4'b0001, 4'b0011, 16'h0000, 32'h5555_aaaa, 6,  1'b1);
    endtask

    function automatic int cycle_budget();
        int total;
        total = reset_cycles + 10 * wb_cycles;
        for (int r = 0; r < num_rows; r++) begin
            total += rows[r].npkt + 6 * wb_cycles + filter_pkg::pipe_latency + 1;
        end
        return 2 * total;
    endfunction

    function automatic filter_pkg::engine_fields_t make_packet(input logic [31:0] cval);
        filter_pkg::engine_fields_t pkt;
        logic [31:0]                r;
        pkt[0] = lcg_next();
        for (int i = 1; i < filter_pkg::num_fields; i++) begin
            r = lcg_next();
            // Copy a neighbour or the constant now and then so eq can hit
            case (r[17:16])
                2'd0:    pkt[i] = pkt[i-1];
                2'd1:    pkt[i] = cval;
                default: pkt[i] = r;
            endcase
        end
        r = lcg_next();
        if (r[20:18] == 3'd0) begin
            for (int i = 1; i < filter_pkg::num_fields; i++) begin
                pkt[i] = pkt[0];
            end
        end
        return pkt;
    endfunction

    // Reference model returns the verdict and the expected fields
    function automatic bit model_packet(input logic [31:0] ctrl, input logic [31:0] cval,
                                        input filter_pkg::engine_fields_t pkt,
                                        output filter_pkg::engine_fields_t result);
        filter_pkg::engine_fields_t orig;
        filter_pkg::engine_fields_t opnd;
        logic [3:0]                 row;
        logic [3:0]                 op;
        bit                         keep;
        bit                         holds;
        int                         src;
        int                         nxt;
        op   = ctrl[3:0];
        keep = 1'b1;
        for (int i = 0; i < filter_pkg::num_fields; i++) begin
            row = ctrl[12 + 4 * i +: 4];
            src = -1;
            for (int j = 0; j < filter_pkg::num_fields; j++) begin
                if (row[j] && src < 0) begin
                    src = j;
                end
            end
            orig[i] = (src < 0) ? pkt[i] : pkt[src];
            opnd[i] = ctrl[8 + i] ? cval : orig[i];
        end
        for (int i = 0; i < filter_pkg::num_fields; i++) begin
            nxt = (i + 1) % filter_pkg::num_fields;
            case (op)
                filter_pkg::filter_gt:     holds = opnd[i] > opnd[nxt];
                filter_pkg::filter_lt:     holds = opnd[i] < opnd[nxt];
                filter_pkg::filter_eq:     holds = opnd[i] == opnd[nxt];
                filter_pkg::filter_not_eq: holds = opnd[i] != opnd[nxt];
                default:                   holds = 1'b1;
            endcase
            if (ctrl[4 + i] && !holds) begin
                keep = 1'b0;
            end
        end
        result = (op == filter_pkg::filter_nop) ? opnd : orig;
        return keep;
    endfunction

    // ------------------------------------------------------------------
    // Wishbone master and checks
    // ------------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge ap_clk);
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // stb stays low for one cycle
        @(negedge ap_clk);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic send_packets(input int r, output int kept, output int dropped);
        filter_pkg::engine_fields_t pkt;
        filter_pkg::engine_fields_t result;
        expect_t                    entry;
        kept    = 0;
        dropped = 0;
        for (int n = 0; n < rows[r].npkt; n++) begin
            pkt       = make_packet(rows[r].cval);
            in_valid  = 1'b1;
            in_fields = pkt;
            if (model_packet(rows[r].ctrl, rows[r].cval, pkt, result)) begin
                entry.fields = result;
                entry.cycle  = cyc_count + filter_pkg::pipe_latency;
                exp_q.push_back(entry);
                kept++;
            end else begin
                dropped++;
            end
            @(negedge ap_clk);
        end
        in_valid = 1'b0;
    endtask

    // Output monitor samples mid-cycle while outputs are stable
    always @(negedge ap_clk) begin : out_monitor
        expect_t head;
        if (rst_n && out_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("An output packet appeared at %0t while none was expected", $time);
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checks++;
                assert (out_fields === head.fields) else begin
                    errors++;
                    $display("Error at %0t: fields expected %h, got %h",
                             $time, head.fields, out_fields);
                end
                check_value("output cycle", head.cycle, cyc_count);
            end
        end
    end

    initial begin
        logic [31:0] rd;
        int          kept;
        int          dropped;
        int          row_err;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        in_valid  = 1'b0;
        in_fields = '0;
        load_table();
        cycle_limit = cycle_budget();
        repeat (reset_cycles) @(negedge ap_clk);
        rst_n = 1'b1;
        @(negedge ap_clk);

        wb_access(1'b0, filter_pkg::reg_ctrl, '0, rd);
        check_value("ctrl after reset", 32'h0, rd);
        wb_access(1'b0, filter_pkg::reg_const, '0, rd);
        check_value("const after reset", 32'h0, rd);

        for (int r = 0; r < num_rows; r++) begin
            row_err = errors;
            wb_access(1'b1, filter_pkg::reg_ctrl, rows[r].ctrl, rd);
            wb_access(1'b1, filter_pkg::reg_const, rows[r].cval, rd);
            wb_access(1'b0, filter_pkg::reg_ctrl, '0, rd);
            check_value("ctrl readback", rows[r].ctrl, rd);
            wb_access(1'b0, filter_pkg::reg_const, '0, rd);
            check_value("const readback", rows[r].cval, rd);
            send_packets(r, kept, dropped);
            pass_total += kept;
            drop_total += dropped;
            // Last packet leaves the pipeline after pipe_latency cycles
            repeat (filter_pkg::pipe_latency + 1) @(negedge ap_clk);
            check_value("pending outputs", 32'd0, exp_q.size());
            if (rows[r].check_counts) begin
                wb_access(1'b0, filter_pkg::reg_pass_count, '0, rd);
                check_value("pass count", pass_total, rd);
                wb_access(1'b0, filter_pkg::reg_drop_count, '0, rd);
                check_value("drop count", drop_total, rd);
            end
            $display("Row %0d: op %0d, %0d kept, %0d dropped, %s", r, rows[r].ctrl[3:0],
                     kept, dropped, (errors == row_err) ? "ok" : "mismatch");
        end

        // Counter addresses ignore writes
        wb_access(1'b1, filter_pkg::reg_pass_count, 32'hffff_0000, rd);
        wb_access(1'b1, filter_pkg::reg_drop_count, 32'h0000_ffff, rd);
        wb_access(1'b0, filter_pkg::reg_pass_count, '0, rd);
        check_value("pass count after write", pass_total, rd);
        wb_access(1'b0, filter_pkg::reg_drop_count, '0, rd);
        check_value("drop count after write", drop_total, rd);

        $display("Summary: %0d checks, %0d errors, %0d passed, %0d dropped",
                 checks, errors, pass_total, drop_total);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/filter_pkg.sv
rtl/filter_cfg_if.sv
rtl/filter_cfg_decode.sv
rtl/filter_cond_kernel.sv
rtl/filter_result_gate.sv
rtl/graph_filter_engine.sv
sim/filter_engine_asserts.sv
sim/tb_graph_filter_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_graph_filter_engine -f tb.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
